// ==== verilog/lsu_pkg.sv ====
`default_nettype none

// shared widths and access codes for the load/store unit
package lsu_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int XLEN          = 32;          // data word
    localparam int XLEN_BYTES    = XLEN / 8;    // byte lanes per word
    localparam int REG_ADDR_BITS = 5;           // rd index
    localparam int WIDTH_BITS    = 3;           // funct3 style width code
    localparam int LANE_BITS     = 2;           // addr bits picking a lane

    // ==============================
    // width codes, same as funct3
    // ==============================
    localparam logic [WIDTH_BITS-1:0] WIDTH_B  = 3'b000;  // LB / SB
    localparam logic [WIDTH_BITS-1:0] WIDTH_H  = 3'b001;  // LH / SH
    localparam logic [WIDTH_BITS-1:0] WIDTH_W  = 3'b010;  // LW / SW
    localparam logic [WIDTH_BITS-1:0] WIDTH_BU = 3'b100;  // LBU
    localparam logic [WIDTH_BITS-1:0] WIDTH_HU = 3'b101;  // LHU

    // size field values, low two bits of the code
    localparam logic [WIDTH_BITS-2:0] SIZE_B = 2'd0;
    localparam logic [WIDTH_BITS-2:0] SIZE_H = 2'd1;
    localparam logic [WIDTH_BITS-2:0] SIZE_W = 2'd2;

    // one width code, seen two ways
    //   raw    -> whole funct3, picks the load extension
    //   fields -> unsigned flag + size, used for mask and alignment
    typedef union packed {
        logic [WIDTH_BITS-1:0] raw;
        struct packed {
            logic                  is_unsigned;  // top bit, U variants
            logic [WIDTH_BITS-2:0] size;         // byte / half / word
        } fields;
    } access_width_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 1, one entry holding register for incoming requests
module lsu_issue #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                clk,
    input  logic                                reset_n,

    // request side
    input  logic                                req_valid,
    input  logic                                req_store,
    input  lsu_pkg::access_width_t              req_width,
    input  logic [ADDR_WIDTH-1:0]               req_addr,
    input  logic [lsu_pkg::XLEN-1:0]            req_wdata,
    input  logic [lsu_pkg::REG_ADDR_BITS-1:0]   req_rd,
    output logic                                req_ready,

    // towards the memory stage
    input  logic                                iss_ready,
    output logic                                iss_valid,
    output logic                                iss_store,
    output lsu_pkg::access_width_t              iss_width,
    output logic [ADDR_WIDTH-1:0]               iss_addr,
    output logic [lsu_pkg::XLEN_BYTES-1:0]      iss_be,
    output logic [lsu_pkg::XLEN-1:0]            iss_wdata,
    output logic [lsu_pkg::REG_ADDR_BITS-1:0]   iss_rd,

    // alignment fault
    output logic                                exception_alignment,
    output logic [ADDR_WIDTH-1:0]               exc_addr
);

    localparam int NB = lsu_pkg::XLEN_BYTES;

    logic                              out_of_reset;  // keeps ready low right after reset
    logic                              accept;
    logic                              misaligned;
    logic [lsu_pkg::LANE_BITS-1:0]     lane;
    logic [NB-1:0]                     base_mask;

    // ==============================
    // accept and alignment check
    // ==============================
    // slot is free or emptying this cycle, a faulted item always leaves
    assign req_ready = out_of_reset & (~iss_valid | iss_ready);
    assign accept    = req_valid & req_ready;
    assign lane      = req_addr[lsu_pkg::LANE_BITS-1:0];

    always_comb begin
        case (req_width.fields.size)
            lsu_pkg::SIZE_B: begin
                misaligned = 1'b0;                        // bytes go anywhere
                base_mask  = {{(NB-1){1'b0}}, 1'b1};
            end
            lsu_pkg::SIZE_H: begin
                misaligned = lane[0];                     // odd address
                base_mask  = {{(NB-2){1'b0}}, 2'b11};
            end
            default: begin
                misaligned = |lane;                       // word, must be lane 0
                base_mask  = {NB{1'b1}};
            end
        endcase
    end

    // ==============================
    // control state
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_of_reset        <= 1'b0;
            iss_valid           <= 1'b0;
            exception_alignment <= 1'b0;
        end else begin
            out_of_reset        <= 1'b1;
            exception_alignment <= accept & misaligned;  // one cycle, then gone
            if (accept) begin
                iss_valid <= ~misaligned;                // bad item never goes on
            end else if (iss_ready) begin
                iss_valid <= 1'b0;                       // handed on
            end
        end
    end

    // payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            iss_store <= req_store;
            iss_width <= req_width;
            iss_addr  <= req_addr;
            iss_be    <= base_mask << lane;
            iss_wdata <= req_wdata << {lane, 3'b000};  // data onto its lanes
            iss_rd    <= req_rd;
        end
    end

    assign exc_addr = iss_addr;  // full byte address of the faulted request

endmodule

`default_nettype wire

// ==== verilog/lsu_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 2, drives the memory port, one access in flight
module lsu_mem_port #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                clk,
    input  logic                                reset_n,

    // from the issue stage
    input  logic                                iss_valid,
    input  logic                                iss_store,
    input  lsu_pkg::access_width_t              iss_width,
    input  logic [ADDR_WIDTH-1:0]               iss_addr,
    input  logic [lsu_pkg::XLEN_BYTES-1:0]      iss_be,
    input  logic [lsu_pkg::XLEN-1:0]            iss_wdata,
    input  logic [lsu_pkg::REG_ADDR_BITS-1:0]   iss_rd,
    output logic                                iss_ready,

    // memory port
    input  logic                                mem_ack,
    input  logic [lsu_pkg::XLEN-1:0]            mem_rdata,
    output logic                                mem_re,
    output logic [lsu_pkg::XLEN_BYTES-1:0]      mem_we,
    output logic [ADDR_WIDTH-1:0]               mem_addr,
    output logic [lsu_pkg::XLEN-1:0]            mem_wdata,

    // towards load alignment, one cycle each
    output logic                                rd_valid,
    output logic [lsu_pkg::XLEN-1:0]            rd_data,
    output logic [lsu_pkg::LANE_BITS-1:0]       rd_lane,
    output lsu_pkg::access_width_t              rd_width,
    output logic [lsu_pkg::REG_ADDR_BITS-1:0]   rd_dest,
    output logic                                wr_ack
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_LOAD  = 2'd1;
    localparam logic [1:0] S_STORE = 2'd2;

    logic [1:0]                        state;
    logic                              start;
    logic                              done;       // ack seen while busy
    logic [lsu_pkg::LANE_BITS-1:0]     lane_q;     // kept for the load shift
    lsu_pkg::access_width_t            width_q;
    logic [lsu_pkg::REG_ADDR_BITS-1:0] dest_q;

    assign iss_ready = (state == S_IDLE);
    assign start     = iss_valid & iss_ready;
    assign done      = (state != S_IDLE) & mem_ack;

    // ==============================
    // access FSM
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= S_IDLE;
            mem_re <= 1'b0;
            mem_we <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= iss_store ? S_STORE : S_LOAD;
                        mem_re <= ~iss_store;
                        mem_we <= iss_store ? iss_be : '0;  // never with mem_re
                    end
                end
                S_LOAD, S_STORE: begin
                    if (mem_ack) begin       // request held until here
                        state  <= S_IDLE;
                        mem_re <= 1'b0;
                        mem_we <= '0;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // access payload, stable for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr  <= {iss_addr[ADDR_WIDTH-1:lsu_pkg::LANE_BITS],
                          {lsu_pkg::LANE_BITS{1'b0}}};  // word aligned
            mem_wdata <= iss_wdata;
            lane_q    <= iss_addr[lsu_pkg::LANE_BITS-1:0];
            width_q   <= iss_width;
            dest_q    <= iss_rd;
        end
    end

    // ==============================
    // completion, in the ack cycle
    // ==============================
    assign rd_valid = done & (state == S_LOAD);
    assign wr_ack   = done & (state == S_STORE);
    assign rd_data  = mem_rdata;  // raw word, shifted in stage 3
    assign rd_lane  = lane_q;
    assign rd_width = width_q;
    assign rd_dest  = dest_q;

endmodule

`default_nettype wire

// ==== verilog/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage 3, lines up the load data and writes it back
module lsu_load_align (
    input  logic                                clk,
    input  logic                                reset_n,

    // from the memory stage
    input  logic                                rd_valid,
    input  logic [lsu_pkg::XLEN-1:0]            rd_data,
    input  logic [lsu_pkg::LANE_BITS-1:0]       rd_lane,
    input  lsu_pkg::access_width_t              rd_width,
    input  logic [lsu_pkg::REG_ADDR_BITS-1:0]   rd_dest,
    input  logic                                wr_ack,

    // register file write port
    output logic                                reg_we,
    output logic [lsu_pkg::REG_ADDR_BITS-1:0]   reg_addr,
    output logic [lsu_pkg::XLEN-1:0]            reg_wdata,

    output logic                                store_done
);

    localparam int XL = lsu_pkg::XLEN;

    logic [XL-1:0] shifted;   // addressed byte now in lane 0
    logic [XL-1:0] extended;

    // ==============================
    // shift and extend
    // ==============================
    assign shifted = rd_data >> {rd_lane, 3'b000};

    always_comb begin
        case (rd_width.raw)
            lsu_pkg::WIDTH_B:  extended = {{(XL-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::WIDTH_H:  extended = {{(XL-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::WIDTH_BU: extended = {{(XL-8){1'b0}}, shifted[7:0]};
            lsu_pkg::WIDTH_HU: extended = {{(XL-16){1'b0}}, shifted[15:0]};
            lsu_pkg::WIDTH_W:  extended = shifted;
            default:           extended = shifted;  // no other codes get issued
        endcase
    end

    // ==============================
    // write back
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reg_we     <= 1'b0;
            store_done <= 1'b0;
        end else begin
            reg_we     <= rd_valid;   // one cycle after the load ack
            store_done <= wr_ack;     // one cycle after the store ack
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            reg_addr  <= rd_dest;
            reg_wdata <= extended;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// load/store unit, issue -> memory access -> load align
module lsu_top #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                clk,
    input  logic                                reset_n,

    // ==============================
    // request side
    // ==============================
    input  logic                                req_valid,
    input  logic                                req_store,
    input  lsu_pkg::access_width_t              req_width,
    input  logic [ADDR_WIDTH-1:0]               req_addr,
    input  logic [lsu_pkg::XLEN-1:0]            req_wdata,
    input  logic [lsu_pkg::REG_ADDR_BITS-1:0]   req_rd,
    output logic                                req_ready,

    // ==============================
    // memory side
    // ==============================
    output logic                                mem_re,
    output logic [lsu_pkg::XLEN_BYTES-1:0]      mem_we,
    output logic [ADDR_WIDTH-1:0]               mem_addr,
    output logic [lsu_pkg::XLEN-1:0]            mem_wdata,
    input  logic                                mem_ack,
    input  logic [lsu_pkg::XLEN-1:0]            mem_rdata,

    // ==============================
    // completion side
    // ==============================
    output logic                                reg_we,
    output logic [lsu_pkg::REG_ADDR_BITS-1:0]   reg_addr,
    output logic [lsu_pkg::XLEN-1:0]            reg_wdata,
    output logic                                store_done,
    output logic                                exception_alignment,
    output logic [ADDR_WIDTH-1:0]               exc_addr
);

    // stage 1 -> stage 2
    logic                              iss_valid;
    logic                              iss_ready;
    logic                              iss_store;
    lsu_pkg::access_width_t            iss_width;
    logic [ADDR_WIDTH-1:0]             iss_addr;
    logic [lsu_pkg::XLEN_BYTES-1:0]    iss_be;
    logic [lsu_pkg::XLEN-1:0]          iss_wdata;
    logic [lsu_pkg::REG_ADDR_BITS-1:0] iss_rd;

    // stage 2 -> stage 3
    logic                              rd_valid;
    logic [lsu_pkg::XLEN-1:0]          rd_data;
    logic [lsu_pkg::LANE_BITS-1:0]     rd_lane;
    lsu_pkg::access_width_t            rd_width;
    logic [lsu_pkg::REG_ADDR_BITS-1:0] rd_dest;
    logic                              wr_ack;

    lsu_issue #(.ADDR_WIDTH(ADDR_WIDTH)) u_issue (
        .clk(clk), .reset_n(reset_n),
        .req_valid(req_valid), .req_store(req_store), .req_width(req_width),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_rd(req_rd),
        .req_ready(req_ready), .iss_ready(iss_ready),
        .iss_valid(iss_valid), .iss_store(iss_store), .iss_width(iss_width),
        .iss_addr(iss_addr), .iss_be(iss_be), .iss_wdata(iss_wdata), .iss_rd(iss_rd),
        .exception_alignment(exception_alignment), .exc_addr(exc_addr)
    );

    lsu_mem_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem_port (
        .clk(clk), .reset_n(reset_n),
        .iss_valid(iss_valid), .iss_store(iss_store), .iss_width(iss_width),
        .iss_addr(iss_addr), .iss_be(iss_be), .iss_wdata(iss_wdata), .iss_rd(iss_rd),
        .iss_ready(iss_ready),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem_re(mem_re), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .rd_valid(rd_valid), .rd_data(rd_data), .rd_lane(rd_lane),
        .rd_width(rd_width), .rd_dest(rd_dest), .wr_ack(wr_ack)
    );

    lsu_load_align u_load_align (
        .clk(clk), .reset_n(reset_n),
        .rd_valid(rd_valid), .rd_data(rd_data), .rd_lane(rd_lane),
        .rd_width(rd_width), .rd_dest(rd_dest), .wr_ack(wr_ack),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .store_done(store_done)
    );

endmodule

`default_nettype wire

// ==== testbench/lsu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// port protocol checks, bound into lsu_top
module lsu_properties #(
    parameter int ADDR_WIDTH = 32
) (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    req_valid,
    input logic                    req_ready,
    input logic                    mem_re,
    input logic [3:0]              mem_we,
    input logic [ADDR_WIDTH-1:0]   mem_addr,
    input logic [31:0]             mem_wdata,
    input logic                    mem_ack,
    input logic                    reg_we,
    input logic                    store_done,
    input logic                    exception_alignment
);

    // ==============================
    // memory port
    // ==============================
    a_re_we_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_re && (|mem_we)))
        else $error("mem_re and mem_we high together");

    // access held until the ack cycle
    a_access_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_re || (|mem_we)) && !mem_ack |=>
            $stable(mem_re) && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("access outputs changed before mem_ack");

    // each high cycle belongs to an accept one cycle earlier, no lingering fault
    a_exc_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        exception_alignment |-> $past(req_valid && req_ready))
        else $error("exception_alignment held without a new request");

    // sampled mid-cycle, after the reset edge has settled
    a_reset_low: assert property (@(negedge clk)
        !reset_n |-> !req_ready && !mem_re && (mem_we == 4'b0000) && !reg_we && !store_done)
        else $error("control output high during reset");

endmodule

bind lsu_top lsu_properties #(.ADDR_WIDTH(ADDR_WIDTH)) props0 (
    .clk(clk), .reset_n(reset_n), .req_valid(req_valid), .req_ready(req_ready),
    .mem_re(mem_re), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .reg_we(reg_we), .store_done(store_done),
    .exception_alignment(exception_alignment)
);

`default_nettype wire

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int          ADDR_WIDTH = 32;
    localparam int          NUM_REQ    = 400;
    localparam int          WAIT_LIMIT = 200;    // cycles for one request to be taken
    localparam int          IDLE_LIMIT = 1000;   // memory port quiet time
    localparam int          RUN_LIMIT  = 40000;
    localparam logic [31:0] BASE       = 32'h0004_2000;  // 64-word window

    logic        clk     = 1'b0;
    logic        reset_n = 1'b0;
    logic        req_valid, req_store, req_ready;
    lsu_pkg::access_width_t req_width;
    logic [31:0] req_addr, req_wdata, mem_addr, mem_wdata, mem_rdata, reg_wdata, exc_addr;
    logic [4:0]  req_rd, reg_addr;
    logic [3:0]  mem_we;
    logic        mem_re, mem_ack, reg_we, store_done, exception_alignment;

    lsu_top #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (
        .clk(clk), .reset_n(reset_n),
        .req_valid(req_valid), .req_store(req_store), .req_width(req_width),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_rd(req_rd), .req_ready(req_ready),
        .mem_re(mem_re), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .store_done(store_done),
        .exception_alignment(exception_alignment), .exc_addr(exc_addr)
    );

    always #2 clk = ~clk;  // 4 ns period

    // ==============================
    // random source and model state
    // ==============================
    logic [15:0] lfsr;
    logic [31:0] ref_mem [64];    // memory once every accepted store has landed
    logic [31:0] mem_model [64];  // memory as the port sees it
    logic        cmp_store_q[$];  // expected completions, request order
    logic [4:0]  cmp_rd_q[$];
    logic [31:0] cmp_data_q[$];
    logic [31:0] exc_q[$];        // expected fault addresses
    logic        acc_store_q[$];  // expected memory accesses
    logic [3:0]  acc_be_q[$];
    logic [31:0] acc_addr_q[$];
    logic [31:0] acc_data_q[$];
    logic        all_done = 1'b0;
    logic        cur_store;
    logic [2:0]  cur_code;
    logic [31:0] cur_addr, cur_wdata;
    logic [4:0]  cur_rd;
    int          n_load, n_store, n_exc;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);    // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // every bit of the byte address feeds the pattern
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [2:0] pick_code(input logic [2:0] idx);
        case (idx)
            3'd0:    return lsu_pkg::WIDTH_B;
            3'd1:    return lsu_pkg::WIDTH_H;
            3'd2:    return lsu_pkg::WIDTH_W;
            3'd3:    return lsu_pkg::WIDTH_BU;
            default: return lsu_pkg::WIDTH_HU;
        endcase
    endfunction

    // addressed byte to bit 0, then extend per funct3
    function automatic logic [31:0] load_value(input logic [31:0] w, input logic [1:0] lane,
                                               input logic [2:0] code);
        logic [31:0] sh;
        sh = w >> (8 * lane);
        case (code)
            lsu_pkg::WIDTH_B:  return {{24{sh[7]}}, sh[7:0]};
            lsu_pkg::WIDTH_H:  return {{16{sh[15]}}, sh[15:0]};
            lsu_pkg::WIDTH_BU: return {24'h0, sh[7:0]};
            lsu_pkg::WIDTH_HU: return {16'h0, sh[15:0]};
            default:           return sh;
        endcase
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_idle(input string label);
        check({label, " req_ready"}, 0, req_ready);
        check({label, " mem_re"}, 0, mem_re);
        check({label, " mem_we"}, 0, mem_we);
        check({label, " reg_we"}, 0, reg_we);
        check({label, " store_done"}, 0, store_done);
        check({label, " exception_alignment"}, 0, exception_alignment);
    endtask

    // expected results for the request just taken
    task automatic model_accept();
        logic [1:0]  lane;
        logic [1:0]  size;
        logic [3:0]  be;
        logic [31:0] sdata;
        logic [5:0]  idx;
        int          b;
        lane = cur_addr[1:0];
        size = cur_code[1:0];
        idx  = cur_addr[7:2];
        if ((size == 2'd1 && lane[0]) || (size == 2'd2 && lane != 2'd0)) begin
            exc_q.push_back(cur_addr);    // fault, nothing reaches memory
            n_exc++;
        end else begin
            be    = (size == 2'd0) ? 4'b0001 : (size == 2'd1) ? 4'b0011 : 4'b1111;
            be    = be << lane;
            sdata = cur_wdata << (8 * lane);
            acc_store_q.push_back(cur_store);
            acc_be_q.push_back(cur_store ? be : 4'b0000);
            acc_addr_q.push_back({cur_addr[31:2], 2'b00});
            acc_data_q.push_back(sdata);
            cmp_store_q.push_back(cur_store);
            cmp_rd_q.push_back(cur_rd);
            if (cur_store) begin
                for (b = 0; b < 4; b++) begin
                    if (be[b]) ref_mem[idx][8*b +: 8] = sdata[8*b +: 8];
                end
                cmp_data_q.push_back('0);
                n_store++;
            end else begin
                cmp_data_q.push_back(load_value(ref_mem[idx], lane, cur_code));
                n_load++;
            end
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin : stimulus
        logic [31:0] r;
        int          gap;
        int          waited;
        logic        accepted;
        int          k;
        lfsr = 16'd59;
        for (k = 0; k < 64; k++) begin
            ref_mem[k]   = fill_word(BASE + 4 * k);
            mem_model[k] = ref_mem[k];
        end
        req_valid = 1'b0;
        req_store = 1'b0;
        req_width = '0;
        req_addr  = '0;
        req_wdata = '0;
        req_rd    = '0;
        n_load    = 0;
        n_store   = 0;
        n_exc     = 0;
        repeat (5) begin
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_idle("first cycle after reset");   // ready still held low
        @(posedge clk);
        for (k = 0; k < NUM_REQ; k++) begin
            rand_bits(2, r);
            gap = r[1] ? r[0] + 1 : 0;    // half the time back-to-back
            rand_bits(1, r);
            cur_store = r[0];
            rand_bits(3, r);
            cur_code = pick_code(r[2:0] % 5);
            if (cur_store) cur_code = cur_code & 3'b011;  // stores: b, h, w
            rand_bits(8, r);
            cur_addr = BASE | r[7:0];
            rand_bits(32, r);
            cur_wdata = r;
            rand_bits(5, r);
            cur_rd = r[4:0];
            if (gap > 0) begin
                req_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            req_valid      <= 1'b1;
            req_store      <= cur_store;
            req_width.raw  <= cur_code;
            req_addr       <= cur_addr;
            req_wdata      <= cur_wdata;
            req_rd         <= cur_rd;
            accepted = 1'b0;
            waited   = 0;
            while (!accepted) begin
                @(negedge clk);
                accepted = (req_ready === 1'b1);  // taken at the coming edge
                @(posedge clk);
                waited++;
                if (!accepted && waited > WAIT_LIMIT) begin
                    $display("timeout: request %0d was never accepted", k);
                    stop_run();
                end
            end
            model_accept();
        end
        req_valid <= 1'b0;
        waited = 0;
        while (cmp_store_q.size() + exc_q.size() + acc_store_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > IDLE_LIMIT) begin
                $display("timeout: outstanding requests never completed");
                stop_run();
            end
        end
        repeat (8) @(negedge clk);   // quiet tail, catches stray pulses
        all_done = 1'b1;
        $display("%0d loads, %0d stores, %0d misaligned", n_load, n_store, n_exc);
        $display("NO ERRORS");
        $finish;
    end

    // ==============================
    // memory model
    // ==============================
    initial begin : mem_responder
        logic [31:0] r;
        int          idle;
        logic        busy;
        logic        exp_store;
        logic [3:0]  exp_be;
        logic [31:0] exp_addr, exp_data;
        int          b;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        while (!all_done) begin
            busy = 1'b0;
            idle = 0;
            while (!busy && !all_done) begin
                @(negedge clk);
                busy = (mem_re === 1'b1) || ((|mem_we) === 1'b1);
                idle++;
                if (!busy && idle > IDLE_LIMIT) begin
                    $display("timeout: memory port saw no access for too long");
                    stop_run();
                end
            end
            if (busy) begin
                if (acc_store_q.size() == 0) begin
                    $display("memory access started with no aligned request pending");
                    stop_run();
                end
                exp_store = acc_store_q.pop_front();
                exp_be    = acc_be_q.pop_front();
                exp_addr  = acc_addr_q.pop_front();
                exp_data  = acc_data_q.pop_front();
                check("access mem_re", !exp_store, mem_re);
                check("access mem_we", exp_be, mem_we);
                check("access mem_addr", exp_addr, mem_addr);
                if (exp_store) check("store mem_wdata", exp_data, mem_wdata);
                rand_bits(2, r);
                repeat (r[1:0]) @(posedge clk);  // ack delay 0 to 3
                @(posedge clk);
                mem_ack   <= 1'b1;
                mem_rdata <= mem_model[exp_addr[7:2]];
                @(posedge clk);
                mem_ack   <= 1'b0;
                if (exp_store) begin
                    for (b = 0; b < 4; b++) begin
                        if (exp_be[b]) mem_model[exp_addr[7:2]][8*b +: 8] = exp_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // ==============================
    // completion monitor
    // ==============================
    initial begin : completion_monitor
        int          cycles;
        logic        exp_store;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        cycles = 0;
        while (!all_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("run went past its cycle limit");
                stop_run();
            end
            if (reg_we === 1'b1 || store_done === 1'b1) begin
                if (cmp_store_q.size() == 0) begin
                    $display("completion seen with nothing outstanding");
                    stop_run();
                end
                exp_store = cmp_store_q.pop_front();
                exp_rd    = cmp_rd_q.pop_front();
                exp_data  = cmp_data_q.pop_front();
                check("completion store_done", exp_store, store_done);  // order check too
                check("completion reg_we", !exp_store, reg_we);
                if (!exp_store) begin
                    check("load reg_addr", exp_rd, reg_addr);
                    check("load reg_wdata", exp_data, reg_wdata);
                end
            end
            if (exception_alignment === 1'b1) begin
                if (exc_q.size() == 0) begin
                    $display("alignment exception for an aligned request");
                    stop_run();
                end
                check("misaligned exc_addr", exc_q.pop_front(), exc_addr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/lsu_pkg.sv
verilog/lsu_issue.sv
verilog/lsu_mem_port.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
testbench/lsu_properties.sv
testbench/lsu_tb.sv
